// ==== project.f ====
hdl/prefetch_pkg.sv
hdl/prefetch_ctrl.sv
hdl/prefetch_addr_gen.sv
hdl/fetch_pc_track.sv
hdl/fetch_fifo.sv
hdl/prefetch_top.sv
tests/prefetch_assertions.sv
tests/prefetch_tb.sv

// ==== tests/prefetch_tb.sv ====
`timescale 1ns/1ps

module prefetch_tb;

  logic                      clk;
  logic                      rst_n;
  prefetch_pkg::fetch_cmd_t  fetch_cmd_i;
  logic                      fetch_ready_i;
  prefetch_pkg::fetch_out_t  fetch_o;
  logic                      busy_o;
  prefetch_pkg::mem_req_t    mem_req_o;
  logic                      mem_ready_i;
  prefetch_pkg::mem_resp_t   mem_resp_i;

  // Accepted requests waiting for their response and the cycle each is due
  logic [31:0]  pend_addr [$];
  int unsigned  pend_due [$];
  // Memory ready mode is 0 for random, 1 for held low and 2 for held high
  int           mem_ready_mode = 0;
  // Fetch ready mode is 0 for random and 1 for held high
  int           fetch_ready_mode = 1;
  int           error_count = 0;
  int           failure_count = 0;
  int           fetch_count = 0;

  prefetch_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_cmd_i   (fetch_cmd_i),
    .fetch_ready_i (fetch_ready_i),
    .fetch_o       (fetch_o),
    .busy_o        (busy_o),
    .mem_req_o     (mem_req_o),
    .mem_ready_i   (mem_ready_i),
    .mem_resp_i    (mem_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and reporting
  ////////////////////////////////////////////////////////////////////////////

  // Memory contents are the scrambled address rotated left by 7
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h5a3c_96e1;
    return {x[24:0], x[31:25]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    failure_count++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Drives on the falling edge and returns just after so outputs have settled
  task automatic drive_cmd(input logic req, input logic branch, input logic [31:0] target);
    @(negedge clk);
    fetch_cmd_i <= '{req: req, branch: branch, branch_addr: target};
    #1;
  endtask

  task automatic wait_fetches(input int n, input int limit);
    int goal;
    int cycles;
    goal   = fetch_count + n;
    cycles = 0;
    while (fetch_count < goal) begin
      if (cycles == limit) begin
        report_failure("timed out waiting for instructions at the fetch output");
        return;
      end
      cycles++;
      @(negedge clk);
      #2;
    end
  endtask

  task automatic wait_outstanding(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (pend_addr.size() < n) begin
      if (cycles == limit) begin
        report_failure("timed out waiting for requests in flight");
        return;
      end
      cycles++;
      @(negedge clk);
      #2;
    end
  endtask

  task automatic wait_idle(input int limit);
    int   cycles;
    logic owed;
    cycles = 0;
    // With req low busy follows the responses memory still owes
    owed = (pend_addr.size() != 0) || mem_resp_i.valid;
    check_value("busy_o", busy_o, owed);
    while (busy_o !== 1'b0) begin
      if (cycles == limit) begin
        report_failure("timed out waiting for busy to drop after the stream stopped");
        return;
      end
      cycles++;
      @(negedge clk);
      #2;
      owed = (pend_addr.size() != 0) || mem_resp_i.valid;
      check_value("busy_o", busy_o, owed);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and ready generation
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    int unsigned cycle_no;
    int unsigned last_due;
    int unsigned due;
    logic [31:0] addr;
    void'($urandom(22480));
    mem_ready_i   = 1'b0;
    fetch_ready_i = 1'b0;
    mem_resp_i    = '0;
    cycle_no      = 0;
    last_due      = 0;
    forever begin
      @(negedge clk);
      cycle_no++;
      // Oldest request answers once its delay has run out
      if (pend_due.size() > 0 && pend_due[0] <= cycle_no) begin
        void'(pend_due.pop_front());
        addr = pend_addr.pop_front();
        mem_resp_i <= '{valid: 1'b1, rdata: mem_word(addr)};
      end else begin
        mem_resp_i <= '0;
      end
      case (mem_ready_mode)
        1:       mem_ready_i <= 1'b0;
        2:       mem_ready_i <= 1'b1;
        default: mem_ready_i <= ($urandom_range(3) != 0);
      endcase
      fetch_ready_i <= (fetch_ready_mode == 1) || ($urandom_range(1) == 1);
      // Note what the next rising edge accepts once the request side has settled
      #5;
      if (rst_n && mem_req_o.valid && mem_ready_i) begin
        due = cycle_no + $urandom_range(3, 1);
        // Keep responses in order with at most one per cycle
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(mem_req_o.addr);
        pend_due.push_back(due);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare
    logic [31:0] exp_pc;
    int          in_flight;
    exp_pc    = '0;
    in_flight = 0;
    forever begin
      @(negedge clk);
      #5;
      if (rst_n) begin
        // A branch starts a new stream at the aligned target
        if (fetch_cmd_i.branch) begin
          exp_pc    = fetch_cmd_i.branch_addr & 32'hffff_fffc;
          in_flight = 0;
        end
        if (mem_req_o.valid && mem_ready_i) begin
          in_flight++;
        end
        if (fetch_o.valid && fetch_ready_i) begin
          check_value("fetch_o.addr", fetch_o.addr, exp_pc);
          check_value("fetch_o.instr", fetch_o.instr, mem_word(exp_pc));
          exp_pc = exp_pc + 32'd4;
          in_flight--;
          fetch_count++;
        end
        // Words of the current stream requested but not yet taken
        if (in_flight > prefetch_pkg::DEPTH) begin
          report_failure("more words requested than the buffer can hold");
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int cycles;
    rst_n       = 1'b0;
    fetch_cmd_i = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;

    // Idle after reset with req low
    @(negedge clk);
    #1;
    check_value("mem_req_o.valid", mem_req_o.valid, 1'b0);
    check_value("fetch_o.valid", fetch_o.valid, 1'b0);
    check_value("busy_o", busy_o, 1'b0);

    // Unaligned branch followed by a plain sequential stream
    drive_cmd(1'b1, 1'b1, 32'h0000_1003);
    drive_cmd(1'b1, 1'b0, 32'h0000_1003);
    wait_fetches(12, 200);

    // Random back-pressure from the fetch stage
    fetch_ready_mode = 0;
    wait_fetches(40, 1000);

    // Mid-stream branch while responses are still in flight
    fetch_ready_mode = 1;
    wait_outstanding(2, 200);
    drive_cmd(1'b1, 1'b1, 32'h0000_2f06);
    drive_cmd(1'b1, 1'b0, 32'h0000_2f06);
    wait_fetches(10, 300);

    // Branch while memory stalls so the target must stay on the port
    mem_ready_mode = 1;
    drive_cmd(1'b1, 1'b1, 32'h0000_0a5d);
    check_value("mem_req_o.addr", mem_req_o.addr, 32'h0000_0a5c);
    repeat (3) begin
      drive_cmd(1'b1, 1'b0, 32'h0000_0a5d);
      check_value("mem_req_o.addr", mem_req_o.addr, 32'h0000_0a5c);
    end
    mem_ready_mode = 2;
    cycles = 0;
    while (!(mem_req_o.valid && mem_ready_i)) begin
      if (cycles == 50) begin
        report_failure("branch target request was never accepted");
        break;
      end
      cycles++;
      @(negedge clk);
      #1;
      check_value("mem_req_o.addr", mem_req_o.addr, 32'h0000_0a5c);
    end
    mem_ready_mode   = 0;
    fetch_ready_mode = 0;
    wait_fetches(8, 300);

    // Stop asking and let everything drain
    fetch_ready_mode = 1;
    drive_cmd(1'b0, 1'b0, 32'h0);
    wait_idle(100);

    $display("Fetches checked: %0d, value errors: %0d, other failures: %0d",
             fetch_count, error_count, failure_count);
    if (error_count == 0 && failure_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/prefetch_assertions.sv ====
`timescale 1ns/1ps

module prefetch_assertions (
  input  logic                            clk,
  input  logic                            rst_n,
  input  prefetch_pkg::fetch_cmd_t        fetch_cmd_i,
  input  logic                            fetch_valid_o,
  input  logic [prefetch_pkg::CNT_W-1:0]  out_cnt_q,
  input  logic                            count_up,
  input  logic                            count_down
);

  // Never more in flight than the buffer can take
  assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= prefetch_pkg::DEPTH)
    else $error("outstanding count above buffer depth");

  // Full count only grows if a response leaves in the same cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    (out_cnt_q == prefetch_pkg::DEPTH) |-> !(count_up && !count_down))
    else $error("outstanding count incremented at buffer depth");

  assert property (@(posedge clk) disable iff (!rst_n)
    fetch_cmd_i.branch |-> fetch_cmd_i.req)
    else $error("branch without fetch request");

  // Words shown in the branch cycle are stale
  assert property (@(posedge clk) disable iff (!rst_n)
    fetch_cmd_i.branch |-> !fetch_valid_o)
    else $error("fetch valid high in branch cycle");

endmodule

bind prefetch_ctrl prefetch_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .fetch_cmd_i   (fetch_cmd_i),
  .fetch_valid_o (fetch_valid_o),
  .out_cnt_q     (out_cnt_q),
  .count_up      (count_up),
  .count_down    (count_down)
);

// ==== hdl/prefetch_top.sv ====
`timescale 1ns/1ps

module prefetch_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // Fetch stage
  input  prefetch_pkg::fetch_cmd_t  fetch_cmd_i,
  input  logic                      fetch_ready_i,
  output prefetch_pkg::fetch_out_t  fetch_o,
  output logic                      busy_o,
  // Instruction memory
  output prefetch_pkg::mem_req_t    mem_req_o,
  input  logic                      mem_ready_i,
  input  prefetch_pkg::mem_resp_t   mem_resp_i
);

  prefetch_pkg::fifo_cmd_t          fifo_cmd;
  prefetch_pkg::addr_sel_e          addr_sel;
  logic                             addr_load;
  logic [prefetch_pkg::ADDR_W-1:0]  req_addr;
  logic [prefetch_pkg::CNT_W-1:0]   fifo_cnt;
  logic                             fifo_empty;
  logic                             req_valid;
  logic                             fetch_valid;
  logic                             fetch_take;
  logic [prefetch_pkg::ADDR_W-1:0]  instr;
  logic [prefetch_pkg::ADDR_W-1:0]  pc;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  prefetch_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_cmd_i   (fetch_cmd_i),
    .fetch_ready_i (fetch_ready_i),
    .mem_ready_i   (mem_ready_i),
    .resp_valid_i  (mem_resp_i.valid),
    .fifo_cnt_i    (fifo_cnt),
    .fifo_empty_i  (fifo_empty),
    .req_valid_o   (req_valid),
    .fetch_valid_o (fetch_valid),
    .busy_o        (busy_o),
    .fifo_cmd_o    (fifo_cmd),
    .addr_sel_o    (addr_sel),
    .addr_load_o   (addr_load)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  prefetch_addr_gen u_addr_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_addr_i (fetch_cmd_i.branch_addr),
    .addr_sel_i    (addr_sel),
    .addr_load_i   (addr_load),
    .req_addr_o    (req_addr)
  );

  // Instruction taken by the fetch stage this cycle
  assign fetch_take = fetch_valid && fetch_ready_i;

  fetch_pc_track u_pc_track (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_cmd_i  (fetch_cmd_i),
    .fetch_take_i (fetch_take),
    .pc_o         (pc)
  );

  fetch_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_cmd_i (fifo_cmd),
    .resp_i     (mem_resp_i),
    .instr_o    (instr),
    .cnt_o      (fifo_cnt),
    .empty_o    (fifo_empty)
  );

  // Pack outputs into the bus bundles
  assign mem_req_o = '{valid: req_valid, addr: req_addr};
  assign fetch_o   = '{valid: fetch_valid, addr: pc, instr: instr};

endmodule

// ==== hdl/fetch_fifo.sv ====
`timescale 1ns/1ps

module fetch_fifo (
  input  logic                              clk,
  input  logic                              rst_n,
  input  prefetch_pkg::fifo_cmd_t           fifo_cmd_i,
  input  prefetch_pkg::mem_resp_t           resp_i,
  output logic [prefetch_pkg::ADDR_W-1:0]   instr_o,
  output logic [prefetch_pkg::CNT_W-1:0]    cnt_o,
  output logic                              empty_o
);

  // Entry storage
  logic [prefetch_pkg::ADDR_W-1:0]  mem_q [prefetch_pkg::DEPTH];

  // Pointers wrap naturally since DEPTH is a power of two
  logic [prefetch_pkg::CNT_W-2:0]   wr_ptr_q;
  logic [prefetch_pkg::CNT_W-2:0]   rd_ptr_q;
  logic [prefetch_pkg::CNT_W-1:0]   cnt_q;
  logic [prefetch_pkg::CNT_W-1:0]   cnt_d;

  logic                             wr_en;
  logic                             rd_en;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake qualification
  ////////////////////////////////////////////////////////////////////////////

  // Write only real response words
  assign wr_en = fifo_cmd_i.push && resp_i.valid;
  assign rd_en = fifo_cmd_i.pop && !empty_o;

  always_comb begin
    cnt_d = cnt_q;
    if (fifo_cmd_i.flush) begin
      cnt_d = '0;
    end else if (wr_en && !rd_en) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!wr_en && rd_en) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (fifo_cmd_i.flush) begin
        // Drop all entries at once
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (rd_en) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // Entry write
  always_ff @(posedge clk) begin
    if (wr_en && !fifo_cmd_i.flush) begin
      mem_q[wr_ptr_q] <= resp_i.rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign empty_o = (cnt_q == '0);
  assign cnt_o   = cnt_q;

  // Empty buffer passes the live response word through
  assign instr_o = empty_o ? resp_i.rdata : mem_q[rd_ptr_q];

endmodule

// ==== hdl/fetch_pc_track.sv ====
`timescale 1ns/1ps

module fetch_pc_track (
  input  logic                              clk,
  input  logic                              rst_n,
  input  prefetch_pkg::fetch_cmd_t          fetch_cmd_i,
  // Fetch valid and ready both high
  input  logic                              fetch_take_i,
  output logic [prefetch_pkg::ADDR_W-1:0]   pc_o
);

  logic [prefetch_pkg::ADDR_W-1:0] pc_q;
  logic [prefetch_pkg::ADDR_W-1:0] pc_d;
  logic [prefetch_pkg::ADDR_W-1:0] aligned_target;

  // Word aligned, same as the request side
  assign aligned_target = fetch_cmd_i.branch_addr &
                          ~(prefetch_pkg::ADDR_W'(prefetch_pkg::WORD_BYTES - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pc_d = pc_q;
    // Branch first, fetch valid is low in that cycle anyway
    if (fetch_cmd_i.branch) begin
      pc_d = aligned_target;
    end else if (fetch_take_i) begin
      pc_d = pc_q + prefetch_pkg::ADDR_W'(prefetch_pkg::WORD_BYTES);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  // Address of the word now at the fetch output
  assign pc_o = pc_q;

endmodule

// ==== hdl/prefetch_addr_gen.sv ====
`timescale 1ns/1ps

module prefetch_addr_gen (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [prefetch_pkg::ADDR_W-1:0]   branch_addr_i,
  input  prefetch_pkg::addr_sel_e           addr_sel_i,
  input  logic                              addr_load_i,
  output logic [prefetch_pkg::ADDR_W-1:0]   req_addr_o
);

  // Clears the byte offset within a word
  logic [prefetch_pkg::ADDR_W-1:0] align_mask;

  logic [prefetch_pkg::ADDR_W-1:0] addr_q;
  logic [prefetch_pkg::ADDR_W-1:0] aligned_branch;
  logic [prefetch_pkg::ADDR_W-1:0] addr_incr;

  ////////////////////////////////////////////////////////////////////////////
  // Candidate addresses
  ////////////////////////////////////////////////////////////////////////////

  assign align_mask     = ~(prefetch_pkg::ADDR_W'(prefetch_pkg::WORD_BYTES - 1));

  // Only whole words are fetched
  assign aligned_branch = branch_addr_i & align_mask;

  // Next sequential word after the last accepted one
  assign addr_incr      = (addr_q & align_mask) +
                          prefetch_pkg::ADDR_W'(prefetch_pkg::WORD_BYTES);

  always_comb begin
    case (addr_sel_i)
      prefetch_pkg::SEL_BRANCH: req_addr_o = aligned_branch;
      // Pending target replayed during branch wait
      prefetch_pkg::SEL_HOLD:   req_addr_o = addr_q;
      prefetch_pkg::SEL_INCR:   req_addr_o = addr_incr;
      default:                  req_addr_o = addr_incr;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (addr_load_i) begin
      addr_q <= req_addr_o;
    end
  end

endmodule

// ==== hdl/prefetch_ctrl.sv ====
`timescale 1ns/1ps

module prefetch_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  // Fetch stage side
  input  prefetch_pkg::fetch_cmd_t            fetch_cmd_i,
  input  logic                                fetch_ready_i,
  // Memory side
  input  logic                                mem_ready_i,
  input  logic                                resp_valid_i,
  // Buffer status
  input  logic [prefetch_pkg::CNT_W-1:0]      fifo_cnt_i,
  input  logic                                fifo_empty_i,
  // Control outputs
  output logic                                req_valid_o,
  output logic                                fetch_valid_o,
  output logic                                busy_o,
  output prefetch_pkg::fifo_cmd_t             fifo_cmd_o,
  output prefetch_pkg::addr_sel_e             addr_sel_o,
  output logic                                addr_load_o
);

  prefetch_pkg::ctrl_state_e            state_q;
  prefetch_pkg::ctrl_state_e            state_d;

  // Requests accepted by memory but not yet answered
  logic [prefetch_pkg::CNT_W-1:0]       out_cnt_q;
  logic [prefetch_pkg::CNT_W-1:0]       out_cnt_d;
  // Responses still to be dropped after a branch
  logic [prefetch_pkg::CNT_W-1:0]       flush_cnt_q;
  logic [prefetch_pkg::CNT_W-1:0]       flush_cnt_d;

  // Buffer words plus words in flight, one bit wider so the sum cannot wrap
  logic [prefetch_pkg::CNT_W:0]         occupancy;

  logic                                 count_up;
  logic                                 count_down;
  logic                                 req_accept;
  logic                                 resp_drop;
  logic                                 bypass;

  ////////////////////////////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////////////////////////////

  assign occupancy   = {1'b0, fifo_cnt_i} + {1'b0, out_cnt_q};

  // Only ask when every word in flight is sure to find a buffer slot
  assign req_valid_o = fetch_cmd_i.req &&
                       (occupancy < (prefetch_pkg::CNT_W+1)'(prefetch_pkg::DEPTH));
  assign req_accept  = req_valid_o && mem_ready_i;

  // Busy while anything is in flight or about to be issued
  assign busy_o      = (out_cnt_q != '0) || req_valid_o;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side and buffer commands
  ////////////////////////////////////////////////////////////////////////////

  // Branch cycle and pending flush both hide whatever arrives
  assign resp_drop     = fetch_cmd_i.branch || (flush_cnt_q != '0);

  assign fetch_valid_o = (!fifo_empty_i || resp_valid_i) && !resp_drop;

  // Live word goes straight out when buffer is empty and the stage takes it
  assign bypass        = fifo_empty_i && fetch_ready_i;

  assign fifo_cmd_o.push  = resp_valid_i && !resp_drop && !bypass;
  assign fifo_cmd_o.pop   = fetch_valid_o && fetch_ready_i && !fifo_empty_i;
  // Buffered words are all older than the branch
  assign fifo_cmd_o.flush = fetch_cmd_i.branch;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding and flush counters
  ////////////////////////////////////////////////////////////////////////////

  assign count_up   = req_accept;
  assign count_down = resp_valid_i;

  always_comb begin
    out_cnt_d = out_cnt_q;
    if (count_up && !count_down) begin
      out_cnt_d = out_cnt_q + 1'b1;
    end else if (!count_up && count_down) begin
      out_cnt_d = out_cnt_q - 1'b1;
    end
  end

  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (fetch_cmd_i.branch) begin
      // Everything in flight at the branch is stale
      flush_cnt_d = out_cnt_q;
      // A response landing now is already dropped
      if (resp_valid_i && (out_cnt_q != '0)) begin
        flush_cnt_d = out_cnt_q - 1'b1;
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Branch wait FSM, picks the request address source
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    addr_sel_o = prefetch_pkg::SEL_INCR;
    case (state_q)
      prefetch_pkg::IDLE: begin
        if (fetch_cmd_i.branch) begin
          addr_sel_o = prefetch_pkg::SEL_BRANCH;
          // Target not taken this cycle, keep it on the port
          if (!req_accept) begin
            state_d = prefetch_pkg::BRANCH_WAIT;
          end
        end
      end
      prefetch_pkg::BRANCH_WAIT: begin
        // A fresh branch replaces the waiting target
        if (fetch_cmd_i.branch) begin
          addr_sel_o = prefetch_pkg::SEL_BRANCH;
        end else begin
          addr_sel_o = prefetch_pkg::SEL_HOLD;
        end
        if (req_accept) begin
          state_d = prefetch_pkg::IDLE;
        end
      end
      default: begin
        state_d = prefetch_pkg::IDLE;
      end
    endcase
  end

  // Capture the target on a branch, and the sent address on acceptance
  assign addr_load_o = fetch_cmd_i.branch || req_accept;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= prefetch_pkg::IDLE;
      out_cnt_q   <= '0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      out_cnt_q   <= out_cnt_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

// ==== hdl/prefetch_pkg.sv ====
package prefetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Address and instruction width
  localparam int ADDR_W     = 32;
  // Bytes per fetch word, used for alignment and increment
  localparam int WORD_BYTES = 4;
  // Buffer entries, also the limit on outstanding requests
  localparam int DEPTH      = 4;
  // One extra bit so a count can reach DEPTH itself
  localparam int CNT_W      = $clog2(DEPTH) + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////////////////////////////////////////

  // Command from the fetch stage
  typedef struct packed {
    logic              req;
    logic              branch;
    logic [ADDR_W-1:0] branch_addr;
  } fetch_cmd_t;

  // Request channel towards instruction memory
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  // Response channel, no ready on this side
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] rdata;
  } mem_resp_t;

  // Address and instruction pair handed to the fetch stage
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] instr;
  } fetch_out_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal control
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {IDLE, BRANCH_WAIT} ctrl_state_e;

  // Buffer command from the controller
  typedef struct packed {
    logic push;
    logic pop;
    logic flush;
  } fifo_cmd_t;

  // Where the request address comes from
  typedef enum logic [1:0] {SEL_BRANCH, SEL_HOLD, SEL_INCR} addr_sel_e;

endpackage
